/* hw/mips_ctrl_pkg.sv */
`default_nettype none

package mips_ctrl_pkg;

    //////////////////////////////////////////////////
    // instruction fields and sequencer state

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [4:0] rt_field_t;
    typedef logic [1:0] cmp_t;

    localparam cmp_t cmp_less = 2'b01;  // first operand below the second

    typedef enum logic [3:0] {
        st_fetch     = 4'd0,
        st_decode    = 4'd1,
        st_execute   = 4'd2,
        st_memory    = 4'd3,
        st_writeback = 4'd4,
        st_idle      = 4'd5
    } cycle_state_t;

    // nop sits at code 0 so a cleared register reads as nop
    typedef enum logic [5:0] {
        in_nop,
        in_addu, in_subu, in_and, in_or, in_xor,
        in_addiu, in_andi, in_ori, in_xori, in_lui,
        in_sll, in_srl, in_sra, in_sllv, in_srlv, in_srav,
        in_slt, in_sltu, in_slti, in_sltiu,
        in_lw, in_lb, in_lbu, in_lh, in_lhu,
        in_sw, in_sb, in_sh,
        in_beq, in_bne, in_bgez, in_bgtz, in_blez, in_bltz,
        in_j, in_jal, in_jr, in_jalr
    } instr_t;

    //////////////////////////////////////////////////
    // datapath select encodings

    typedef enum logic [1:0] {dst_rt, dst_rd, dst_ra} reg_dst_t;
    typedef enum logic [1:0] {
        pcs_alu_result, pcs_alu_out, pcs_pc_plus, pcs_jump_target
    } pc_src_t;
    typedef enum logic [1:0] {iord_pc, iord_alu_out, iord_alu_out_aligned} iord_t;
    typedef enum logic [1:0] {srca_pc, srca_reg_a, srca_upper} alu_src_a_t;
    typedef enum logic [2:0] {
        srcb_reg_b, srcb_four, srcb_imm_ext, srcb_imm_shifted,
        srcb_shamt, srcb_reg_shamt, srcb_zero
    } alu_src_b_t;
    typedef enum logic [1:0] {
        m2r_alu_out, m2r_mem_data, m2r_slt_flag, m2r_link_addr
    } mem_to_reg_t;
    typedef enum logic [1:0] {
        ext_zero  = 2'b00,
        ext_sign  = 2'b10,
        ext_upper = 2'b11
    } ext_mode_t;
    typedef enum logic [2:0] {
        lmask_word, lmask_half_signed, lmask_half_unsigned,
        lmask_byte_signed, lmask_byte_unsigned
    } load_mask_t;
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_sll, alu_srl, alu_sra
    } alu_op_t;

    //////////////////////////////////////////////////
    // control bundles

    typedef struct packed {
        reg_dst_t    reg_dst;
        pc_src_t     pc_src;
        alu_src_a_t  alu_src_a;
        alu_src_b_t  alu_src_b;
        mem_to_reg_t mem_to_reg;
        ext_mode_t   ext_mode;
        logic        extend_mux;
    } dp_sel_t;

    typedef struct packed {
        logic ir_write;
        logic pc_write;
        logic reg_write;
        logic alt_pc_write;
        logic alt_pc_mux;
        logic link_en;
        logic link_in;
    } dp_strobe_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    ab_switch;
        logic    slt_bool;
    } alu_ctl_t;

    typedef struct packed {
        logic       mem_read;
        logic       mem_write;
        iord_t      iord;
        load_mask_t load_mask;
        logic       byte_store_en;
        logic       half_store_en;
    } mem_ctl_t;

    function automatic logic is_load(instr_t i);
        return i inside {in_lw, in_lb, in_lbu, in_lh, in_lhu};
    endfunction

    function automatic logic is_store(instr_t i);
        return i inside {in_sw, in_sb, in_sh};
    endfunction

    function automatic logic is_branch(instr_t i);
        return i inside {in_beq, in_bne, in_bgez, in_bgtz, in_blez, in_bltz};
    endfunction

    function automatic logic is_shift(instr_t i);
        return i inside {in_sll, in_srl, in_sra, in_sllv, in_srlv, in_srav};
    endfunction

    function automatic logic is_slt(instr_t i);
        return i inside {in_slt, in_sltu, in_slti, in_sltiu};
    endfunction

endpackage

`default_nettype wire

/* hw/instr_classifier.sv */
`timescale 1ns/100ps
`default_nettype none

module instr_classifier import mips_ctrl_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  cycle_state_t state,
    input  opcode_t      mem_opcode,
    input  funct_t       mem_function,
    input  rt_field_t    mem_info,
    output instr_t       instr
);

    instr_t instr_dec;
    instr_t instr_q;

    //////////////////////////////////////////////////
    // field decode

    always_comb begin
        instr_dec = in_nop;
        case (mem_opcode)
            6'b000000: begin  // special group keyed by the function field
                case (mem_function)
                    6'b000000: instr_dec = in_sll;
                    6'b000010: instr_dec = in_srl;
                    6'b000011: instr_dec = in_sra;
                    6'b000100: instr_dec = in_sllv;
                    6'b000110: instr_dec = in_srlv;
                    6'b000111: instr_dec = in_srav;
                    6'b001000: instr_dec = in_jr;
                    6'b001001: instr_dec = in_jalr;
                    6'b100001: instr_dec = in_addu;
                    6'b100011: instr_dec = in_subu;
                    6'b100100: instr_dec = in_and;
                    6'b100101: instr_dec = in_or;
                    6'b100110: instr_dec = in_xor;
                    6'b101010: instr_dec = in_slt;
                    6'b101011: instr_dec = in_sltu;
                    default:   instr_dec = in_nop;
                endcase
            end
            6'b000001: begin  // regimm branches keyed by rt
                case (mem_info)
                    5'b00000: instr_dec = in_bltz;
                    5'b00001: instr_dec = in_bgez;
                    default:  instr_dec = in_nop;
                endcase
            end
            6'b000010: instr_dec = in_j;
            6'b000011: instr_dec = in_jal;
            6'b000100: instr_dec = in_beq;
            6'b000101: instr_dec = in_bne;
            6'b000110: instr_dec = (mem_info == 5'b00000) ? in_blez : in_nop;
            6'b000111: instr_dec = (mem_info == 5'b00000) ? in_bgtz : in_nop;
            6'b001001: instr_dec = in_addiu;
            6'b001010: instr_dec = in_slti;
            6'b001011: instr_dec = in_sltiu;
            6'b001100: instr_dec = in_andi;
            6'b001101: instr_dec = in_ori;
            6'b001110: instr_dec = in_xori;
            6'b001111: instr_dec = in_lui;
            6'b100000: instr_dec = in_lb;
            6'b100001: instr_dec = in_lh;
            6'b100011: instr_dec = in_lw;
            6'b100100: instr_dec = in_lbu;
            6'b100101: instr_dec = in_lhu;
            6'b101000: instr_dec = in_sb;
            6'b101001: instr_dec = in_sh;
            6'b101011: instr_dec = in_sw;
            default:   instr_dec = in_nop;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            instr_q <= in_nop;
        end else if (state == st_decode) begin
            instr_q <= instr_dec;  // captured as decode ends
        end
    end

    // decode sees the live fields, later states the captured class
    assign instr = (state == st_decode) ? instr_dec : instr_q;

endmodule

`default_nettype wire

/* hw/datapath_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module datapath_ctrl import mips_ctrl_pkg::*; (
    input  cycle_state_t state,
    input  instr_t       instr,
    output dp_sel_t      dp_sel,
    output dp_strobe_t   dp_strobe
);

    logic imm_alu;    // immediate forms, lui included
    logic r_type;     // destination comes from rd
    logic alu_write;  // results written back in the memory cycle
    logic link_jump;
    logic sign_ext;

    assign imm_alu   = instr inside {in_addiu, in_andi, in_ori, in_xori, in_lui,
                                     in_slti, in_sltiu};
    assign r_type    = instr inside {in_addu, in_subu, in_and, in_or, in_xor,
                                     in_slt, in_sltu, in_jr, in_jalr} || is_shift(instr);
    assign alu_write = instr inside {in_addu, in_subu, in_and, in_or, in_xor}
                       || imm_alu || is_shift(instr) || is_slt(instr);
    assign link_jump = instr inside {in_jal, in_jalr};
    assign sign_ext  = instr inside {in_addiu, in_slti, in_sltiu}
                       || is_load(instr) || is_store(instr) || is_branch(instr);

    always_comb begin
        dp_sel.reg_dst    = dst_rt;
        dp_sel.pc_src     = pcs_alu_result;
        dp_sel.alu_src_a  = srca_pc;
        dp_sel.alu_src_b  = srcb_reg_b;
        dp_sel.mem_to_reg = m2r_alu_out;
        dp_sel.extend_mux = (state != st_fetch);
        dp_strobe         = '0;

        if (instr == in_lui) begin
            dp_sel.ext_mode = ext_upper;
        end else if (sign_ext) begin
            dp_sel.ext_mode = ext_sign;
        end else begin
            dp_sel.ext_mode = ext_zero;  // logical immediates and the rest
        end

        case (state)
            st_fetch: begin
                dp_sel.alu_src_b   = srcb_four;  // pc + 4
                dp_strobe.ir_write = 1'b1;
                dp_strobe.pc_write = 1'b1;
            end
            st_decode: begin
                dp_sel.pc_src          = pcs_pc_plus;
                dp_sel.alu_src_b       = srcb_imm_shifted;  // branch target on the side
                dp_strobe.alt_pc_write = instr inside {in_j, in_jal};
                dp_strobe.alt_pc_mux   = 1'b1;
            end
            st_execute: begin
                dp_sel.pc_src    = pcs_alu_out;
                dp_sel.alu_src_a = (instr == in_lui) ? srca_upper : srca_reg_a;
                if (imm_alu || is_load(instr) || is_store(instr)) begin
                    dp_sel.alu_src_b = srcb_imm_ext;
                end else if (instr inside {in_sll, in_srl, in_sra}) begin
                    dp_sel.alu_src_b = srcb_shamt;
                end else if (instr inside {in_sllv, in_srlv, in_srav}) begin
                    dp_sel.alu_src_b = srcb_reg_shamt;
                end else if (instr inside {in_jr, in_jalr}) begin
                    dp_sel.alu_src_b = srcb_zero;  // rs passes through the ALU
                end
                dp_strobe.alt_pc_write = is_branch(instr);
                dp_strobe.link_en      = 1'b1;
                dp_strobe.link_in      = link_jump;
            end
            st_memory: begin
                dp_sel.pc_src          = pcs_alu_out;
                dp_sel.reg_dst         = r_type ? dst_rd : dst_rt;
                dp_sel.mem_to_reg      = is_slt(instr) ? m2r_slt_flag : m2r_alu_out;
                dp_strobe.reg_write    = alu_write;
                dp_strobe.alt_pc_write = instr inside {in_jr, in_jalr};
            end
            st_writeback: begin
                dp_sel.pc_src        = pcs_pc_plus;
                dp_sel.reg_dst       = link_jump ? dst_ra : dst_rt;
                dp_sel.mem_to_reg    = link_jump ? m2r_link_addr : m2r_mem_data;
                dp_strobe.reg_write  = is_load(instr) || link_jump;
                dp_strobe.alt_pc_mux = 1'b1;
            end
            default: begin  // idle holds every strobe off
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/alu_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module alu_ctrl import mips_ctrl_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  cycle_state_t state,
    input  instr_t       instr,
    input  cmp_t         cond,
    input  cmp_t         condu,
    output alu_ctl_t     alu_ctl
);

    logic    exec;
    logic    slt_next;
    logic    slt_q;
    alu_op_t op_exec;

    assign exec = (state == st_execute);

    always_comb begin
        case (instr)
            in_and, in_andi:  op_exec = alu_and;
            in_or, in_ori:    op_exec = alu_or;
            in_xor, in_xori:  op_exec = alu_xor;
            in_sll, in_sllv:  op_exec = alu_sll;
            in_srl, in_srlv:  op_exec = alu_srl;
            in_sra, in_srav:  op_exec = alu_sra;
            in_subu:          op_exec = alu_sub;
            default: begin
                // compares run as a subtract as well
                op_exec = (is_branch(instr) || is_slt(instr)) ? alu_sub : alu_add;
            end
        endcase
    end

    assign slt_next = ((instr inside {in_slt, in_slti}) && (cond == cmp_less))
                      || ((instr inside {in_sltu, in_sltiu}) && (condu == cmp_less));

    always_ff @(posedge clk) begin
        if (rst) begin
            slt_q <= 1'b0;
        end else if (exec) begin
            slt_q <= slt_next;  // held for the write in the memory cycle
        end
    end

    always_comb begin
        alu_ctl.alu_op    = exec ? op_exec : alu_add;
        alu_ctl.ab_switch = exec && is_shift(instr);  // shifted value rides on port b
        alu_ctl.slt_bool  = slt_q;
    end

endmodule

`default_nettype wire

/* hw/mem_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_ctrl import mips_ctrl_pkg::*; (
    input  cycle_state_t state,
    input  instr_t       instr,
    output mem_ctl_t     mem_ctl
);

    always_comb begin
        mem_ctl.mem_read      = 1'b0;
        mem_ctl.mem_write     = 1'b0;
        mem_ctl.iord          = iord_pc;
        mem_ctl.load_mask     = lmask_word;
        mem_ctl.byte_store_en = 1'b0;
        mem_ctl.half_store_en = 1'b0;

        case (state)
            st_fetch: begin
                mem_ctl.mem_read = 1'b1;  // instruction read at the pc
            end
            st_memory: begin
                mem_ctl.mem_read  = is_load(instr);
                mem_ctl.mem_write = is_store(instr);
                if (instr inside {in_lw, in_sw}) begin
                    mem_ctl.iord = iord_alu_out;
                end else if (is_load(instr) || is_store(instr)) begin
                    mem_ctl.iord = iord_alu_out_aligned;  // sub-word access
                end
                mem_ctl.byte_store_en = (instr == in_sb);
                mem_ctl.half_store_en = (instr == in_sh);
            end
            st_writeback: begin
                mem_ctl.mem_read = 1'b1;
                case (instr)
                    in_lb:   mem_ctl.load_mask = lmask_byte_signed;
                    in_lbu:  mem_ctl.load_mask = lmask_byte_unsigned;
                    in_lh:   mem_ctl.load_mask = lmask_half_signed;
                    in_lhu:  mem_ctl.load_mask = lmask_half_unsigned;
                    default: mem_ctl.load_mask = lmask_word;
                endcase
            end
            default: begin
                mem_ctl.mem_read = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hw/mips_ctrl_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mips_ctrl_top import mips_ctrl_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  cycle_state_t state,
    input  opcode_t      mem_opcode,
    input  funct_t       mem_function,
    input  rt_field_t    mem_info,
    input  cmp_t         cond,
    input  cmp_t         condu,
    output dp_sel_t      dp_sel,
    output dp_strobe_t   dp_strobe,
    output alu_ctl_t     alu_ctl,
    output mem_ctl_t     mem_ctl
);

    instr_t instr;  // class of the instruction in flight

    instr_classifier u_instr_classifier (
        .clk          (clk),
        .rst          (rst),
        .state        (state),
        .mem_opcode   (mem_opcode),
        .mem_function (mem_function),
        .mem_info     (mem_info),
        .instr        (instr)
    );

    datapath_ctrl u_datapath_ctrl (
        .state     (state),
        .instr     (instr),
        .dp_sel    (dp_sel),
        .dp_strobe (dp_strobe)
    );

    alu_ctrl u_alu_ctrl (
        .clk     (clk),
        .rst     (rst),
        .state   (state),
        .instr   (instr),
        .cond    (cond),
        .condu   (condu),
        .alu_ctl (alu_ctl)
    );

    mem_ctrl u_mem_ctrl (
        .state   (state),
        .instr   (instr),
        .mem_ctl (mem_ctl)
    );

endmodule

`default_nettype wire

/* verification/tb_clk_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    localparam time half_period = 10;  // 20 ns clock

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;  // released away from the sampling edge
    end

endmodule

`default_nettype wire

/* verification/mips_ctrl_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module mips_ctrl_assert import mips_ctrl_pkg::*; (
    input logic         clk,
    input logic         rst,
    input cycle_state_t state,
    input dp_strobe_t   dp_strobe,
    input mem_ctl_t     mem_ctl
);

    int assert_failures = 0;  // read by the testbench at the end of the run

    a_no_read_write: assert property (@(posedge clk) disable iff (rst)
        !(mem_ctl.mem_read && mem_ctl.mem_write))
        else begin
            $error("memory read and write asserted in the same cycle");
            assert_failures++;
        end

    a_no_early_reg_write: assert property (@(posedge clk) disable iff (rst)
        (state inside {st_fetch, st_decode}) |-> !dp_strobe.reg_write)
        else begin
            $error("register write raised in fetch or decode");
            assert_failures++;
        end

    a_ir_write_in_fetch: assert property (@(posedge clk) disable iff (rst)
        dp_strobe.ir_write |-> (state == st_fetch))
        else begin
            $error("instruction register written outside fetch");
            assert_failures++;
        end

endmodule

bind mips_ctrl_top mips_ctrl_assert u_mips_ctrl_assert (
    .clk       (clk),
    .rst       (rst),
    .state     (state),
    .dp_strobe (dp_strobe),
    .mem_ctl   (mem_ctl)
);

`default_nettype wire

/* verification/tb_mips_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_mips_ctrl import mips_ctrl_pkg::*;;

    localparam int   n_instr       = 300;
    localparam int   cycle_budget  = n_instr * 8 + 16;  // five states plus up to three idles
    localparam int   timeout_limit = 6 * cycle_budget;
    localparam cmp_t less_code     = 2'b01;  // first operand below the second

    logic         clk;
    logic         rst;
    cycle_state_t state;
    opcode_t      mem_opcode;
    funct_t       mem_function;
    rt_field_t    mem_info;
    cmp_t         cond;
    cmp_t         condu;
    dp_sel_t      dp_sel;
    dp_strobe_t   dp_strobe;
    alu_ctl_t     alu_ctl;
    mem_ctl_t     mem_ctl;

    logic [16:0]  enc_fields [$];  // opcode, function and rt of each encoding
    instr_t       enc_class [$];
    instr_t       fields_class;    // class of the fields now on the inputs
    instr_t       held;            // class the decoder keeps after decode
    logic         slt_model;
    cycle_state_t cur_state;
    instr_t       cur_class;
    int           errors = 0;
    int           checks = 0;
    int           cycle_count = 0;

    tb_clk_gen u_tb_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    mips_ctrl_top u_mips_ctrl_top (
        .clk          (clk),
        .rst          (rst),
        .state        (state),
        .mem_opcode   (mem_opcode),
        .mem_function (mem_function),
        .mem_info     (mem_info),
        .cond         (cond),
        .condu        (condu),
        .dp_sel       (dp_sel),
        .dp_strobe    (dp_strobe),
        .alu_ctl      (alu_ctl),
        .mem_ctl      (mem_ctl)
    );

    //////////////////////////////////////////////////
    // reference model of the control rules

    function automatic logic load_class(instr_t c);
        return c inside {in_lw, in_lb, in_lbu, in_lh, in_lhu};
    endfunction

    function automatic logic store_class(instr_t c);
        return c inside {in_sw, in_sb, in_sh};
    endfunction

    function automatic logic branch_class(instr_t c);
        return c inside {in_beq, in_bne, in_bgez, in_bgtz, in_blez, in_bltz};
    endfunction

    function automatic logic shift_class(instr_t c);
        return c inside {in_sll, in_srl, in_sra, in_sllv, in_srlv, in_srav};
    endfunction

    function automatic logic compare_class(instr_t c);
        return c inside {in_slt, in_sltu, in_slti, in_sltiu};
    endfunction

    function automatic logic link_class(instr_t c);
        return c inside {in_jal, in_jalr};
    endfunction

    function automatic alu_op_t exec_op(instr_t c);
        case (c)
            in_and, in_andi: return alu_and;
            in_or, in_ori:   return alu_or;
            in_xor, in_xori: return alu_xor;
            in_sll, in_sllv: return alu_sll;
            in_srl, in_srlv: return alu_srl;
            in_sra, in_srav: return alu_sra;
            default:         return (c == in_subu || branch_class(c) || compare_class(c))
                                    ? alu_sub : alu_add;
        endcase
    endfunction

    function automatic alu_src_b_t exec_src_b(instr_t c);
        if (c inside {in_addiu, in_andi, in_ori, in_xori, in_lui, in_slti, in_sltiu}
                || load_class(c) || store_class(c)) begin
            return srcb_imm_ext;
        end else if (c inside {in_sll, in_srl, in_sra}) begin
            return srcb_shamt;
        end else if (c inside {in_sllv, in_srlv, in_srav}) begin
            return srcb_reg_shamt;
        end else if (c inside {in_jr, in_jalr}) begin
            return srcb_zero;
        end
        return srcb_reg_b;
    endfunction

    function automatic ext_mode_t ext_of(instr_t c);
        if (c == in_lui) begin
            return ext_upper;
        end else if (c inside {in_addiu, in_slti, in_sltiu} || load_class(c)
                     || store_class(c) || branch_class(c)) begin
            return ext_sign;  // offsets and arithmetic immediates
        end
        return ext_zero;
    endfunction

    function automatic load_mask_t mask_of(instr_t c);
        case (c)
            in_lb:   return lmask_byte_signed;
            in_lbu:  return lmask_byte_unsigned;
            in_lh:   return lmask_half_signed;
            in_lhu:  return lmask_half_unsigned;
            default: return lmask_word;
        endcase
    endfunction

    task automatic check_value(input string what, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s in %s for %s, got %0h expected %0h",
                     $time, what, cur_state.name(), cur_class.name(), got, exp);
        end
    endtask

    task automatic check_outputs(input cycle_state_t st, input instr_t c);
        dp_strobe_t s;
        mem_ctl_t   m;
        alu_op_t    op;
        s = '0;
        m = '0;
        m.iord = iord_pc;
        m.load_mask = lmask_word;
        op = alu_add;
        case (st)
            st_fetch: begin
                s.ir_write = 1'b1;
                s.pc_write = 1'b1;
                m.mem_read = 1'b1;
                check_value("pc_src", dp_sel.pc_src, pcs_alu_result);
                check_value("alu_src_b", dp_sel.alu_src_b, srcb_four);
            end
            st_decode: begin
                s.alt_pc_write = c inside {in_j, in_jal};
                check_value("pc_src", dp_sel.pc_src, pcs_pc_plus);
                check_value("alu_src_b", dp_sel.alu_src_b, srcb_imm_shifted);
            end
            st_execute: begin
                s.alt_pc_write = branch_class(c);
                s.link_en = 1'b1;
                s.link_in = link_class(c);
                op = exec_op(c);
                check_value("alu_src_a", dp_sel.alu_src_a,
                            (c == in_lui) ? srca_upper : srca_reg_a);
                check_value("alu_src_b", dp_sel.alu_src_b, exec_src_b(c));
            end
            st_memory: begin
                s.reg_write = c inside {in_addu, in_subu, in_and, in_or, in_xor, in_addiu,
                                        in_andi, in_ori, in_xori, in_lui}
                              || shift_class(c) || compare_class(c);
                s.alt_pc_write = c inside {in_jr, in_jalr};
                m.mem_read = load_class(c);
                m.mem_write = store_class(c);
                if (c inside {in_lw, in_sw}) begin
                    m.iord = iord_alu_out;
                end else if (load_class(c) || store_class(c)) begin
                    m.iord = iord_alu_out_aligned;
                end
                m.byte_store_en = (c == in_sb);
                m.half_store_en = (c == in_sh);
                check_value("reg_dst", dp_sel.reg_dst,
                            (c inside {in_addu, in_subu, in_and, in_or, in_xor, in_slt,
                                       in_sltu, in_jr, in_jalr} || shift_class(c))
                            ? dst_rd : dst_rt);
                check_value("mem_to_reg", dp_sel.mem_to_reg,
                            compare_class(c) ? m2r_slt_flag : m2r_alu_out);
            end
            st_writeback: begin
                s.reg_write = load_class(c) || link_class(c);
                m.mem_read = 1'b1;
                m.load_mask = mask_of(c);
                if (load_class(c)) begin
                    check_value("mem_to_reg", dp_sel.mem_to_reg, m2r_mem_data);
                    check_value("reg_dst", dp_sel.reg_dst, dst_rt);
                end else if (link_class(c)) begin
                    check_value("mem_to_reg", dp_sel.mem_to_reg, m2r_link_addr);
                    check_value("reg_dst", dp_sel.reg_dst, dst_ra);
                end
            end
            default: begin
                check_value("alt_pc_mux", dp_strobe.alt_pc_mux, 1'b0);  // idle stalls quietly
            end
        endcase
        check_value("ir_write", dp_strobe.ir_write, s.ir_write);
        check_value("pc_write", dp_strobe.pc_write, s.pc_write);
        check_value("reg_write", dp_strobe.reg_write, s.reg_write);
        check_value("alt_pc_write", dp_strobe.alt_pc_write, s.alt_pc_write);
        check_value("link_en", dp_strobe.link_en, s.link_en);
        check_value("link_in", dp_strobe.link_in, s.link_in);
        check_value("mem_read", mem_ctl.mem_read, m.mem_read);
        check_value("mem_write", mem_ctl.mem_write, m.mem_write);
        check_value("iord", mem_ctl.iord, m.iord);
        check_value("load_mask", mem_ctl.load_mask, m.load_mask);
        check_value("byte_store_en", mem_ctl.byte_store_en, m.byte_store_en);
        check_value("half_store_en", mem_ctl.half_store_en, m.half_store_en);
        check_value("alu_op", alu_ctl.alu_op, op);
        check_value("ab_switch", alu_ctl.ab_switch, (st == st_execute) && shift_class(c));
        check_value("slt_bool", alu_ctl.slt_bool, slt_model);
        check_value("ext_mode", dp_sel.ext_mode, ext_of(c));
    endtask

    //////////////////////////////////////////////////
    // stimulus

    task automatic add_encoding(input opcode_t op, input funct_t fn, input rt_field_t rt,
                                input instr_t c);
        enc_fields.push_back({op, fn, rt});
        enc_class.push_back(c);
    endtask

    task automatic pick_instruction();
        int          k;
        logic [16:0] f;
        k = $urandom_range(0, enc_class.size() - 1);
        f = enc_fields[k];
        fields_class = enc_class[k];
        mem_opcode = f[16:11];
        mem_function = f[10:5];
        mem_info = f[4:0];
        if (mem_opcode != 6'h00) begin
            mem_function = funct_t'($urandom);  // function field unused here
        end
        if (!(mem_opcode inside {6'h01, 6'h06, 6'h07})) begin
            mem_info = rt_field_t'($urandom);
        end
    endtask

    task automatic step(input cycle_state_t st);
        state = st;
        cond = cmp_t'($urandom);
        condu = cmp_t'($urandom);
        if (st != st_decode) begin
            mem_opcode = opcode_t'($urandom);  // the class must come from the decode cycle
            mem_function = funct_t'($urandom);
            mem_info = rt_field_t'($urandom);
        end
        if (st == st_decode) begin
            held = fields_class;
        end
        if (st == st_execute) begin
            slt_model = (held inside {in_slt, in_slti} && cond == less_code)
                        || (held inside {in_sltu, in_sltiu} && condu == less_code);
        end
        cur_state = st;
        cur_class = held;
        @(negedge clk);
        check_outputs(st, held);
    endtask

    task automatic build_encodings();
        add_encoding(6'h00, 6'h21, 5'h00, in_addu);
        add_encoding(6'h00, 6'h23, 5'h00, in_subu);
        add_encoding(6'h00, 6'h24, 5'h00, in_and);
        add_encoding(6'h00, 6'h25, 5'h00, in_or);
        add_encoding(6'h00, 6'h26, 5'h00, in_xor);
        add_encoding(6'h00, 6'h2a, 5'h00, in_slt);
        add_encoding(6'h00, 6'h2b, 5'h00, in_sltu);
        add_encoding(6'h00, 6'h00, 5'h00, in_sll);
        add_encoding(6'h00, 6'h02, 5'h00, in_srl);
        add_encoding(6'h00, 6'h03, 5'h00, in_sra);
        add_encoding(6'h00, 6'h04, 5'h00, in_sllv);
        add_encoding(6'h00, 6'h06, 5'h00, in_srlv);
        add_encoding(6'h00, 6'h07, 5'h00, in_srav);
        add_encoding(6'h00, 6'h08, 5'h00, in_jr);
        add_encoding(6'h00, 6'h09, 5'h00, in_jalr);
        add_encoding(6'h09, 6'h00, 5'h00, in_addiu);
        add_encoding(6'h0a, 6'h00, 5'h00, in_slti);
        add_encoding(6'h0b, 6'h00, 5'h00, in_sltiu);
        add_encoding(6'h0c, 6'h00, 5'h00, in_andi);
        add_encoding(6'h0d, 6'h00, 5'h00, in_ori);
        add_encoding(6'h0e, 6'h00, 5'h00, in_xori);
        add_encoding(6'h0f, 6'h00, 5'h00, in_lui);
        add_encoding(6'h20, 6'h00, 5'h00, in_lb);
        add_encoding(6'h21, 6'h00, 5'h00, in_lh);
        add_encoding(6'h23, 6'h00, 5'h00, in_lw);
        add_encoding(6'h24, 6'h00, 5'h00, in_lbu);
        add_encoding(6'h25, 6'h00, 5'h00, in_lhu);
        add_encoding(6'h28, 6'h00, 5'h00, in_sb);
        add_encoding(6'h29, 6'h00, 5'h00, in_sh);
        add_encoding(6'h2b, 6'h00, 5'h00, in_sw);
        add_encoding(6'h04, 6'h00, 5'h00, in_beq);
        add_encoding(6'h05, 6'h00, 5'h00, in_bne);
        add_encoding(6'h06, 6'h00, 5'h00, in_blez);
        add_encoding(6'h07, 6'h00, 5'h00, in_bgtz);
        add_encoding(6'h01, 6'h00, 5'h00, in_bltz);
        add_encoding(6'h01, 6'h00, 5'h01, in_bgez);
        add_encoding(6'h02, 6'h00, 5'h00, in_j);
        add_encoding(6'h03, 6'h00, 5'h00, in_jal);
        add_encoding(6'h00, 6'h18, 5'h00, in_nop);  // mult is not supported
        add_encoding(6'h00, 6'h10, 5'h00, in_nop);  // mfhi
        add_encoding(6'h22, 6'h00, 5'h00, in_nop);  // lwl
        add_encoding(6'h26, 6'h00, 5'h00, in_nop);  // lwr
        add_encoding(6'h01, 6'h00, 5'h11, in_nop);  // bgezal
        add_encoding(6'h06, 6'h00, 5'h01, in_nop);  // blez needs rt of zero
        add_encoding(6'h3f, 6'h00, 5'h00, in_nop);
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > timeout_limit) begin
            $display("timeout: run did not end within %0d cycles", timeout_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        int assert_fails;
        state = st_idle;
        mem_opcode = '0;
        mem_function = '0;
        mem_info = '0;
        cond = '0;
        condu = '0;
        fields_class = in_nop;
        held = in_nop;
        slt_model = 1'b0;
        void'($urandom(63));
        build_encodings();
        wait (rst === 1'b0);
        @(negedge clk);

        // the class register starts as nop, so nothing may write
        step(st_execute);
        step(st_memory);
        step(st_writeback);
        step(st_idle);

        for (int i = 0; i < n_instr; i++) begin
            step(st_fetch);
            pick_instruction();
            step(st_decode);
            repeat ($urandom_range(0, 1)) step(st_idle);
            step(st_execute);
            step(st_memory);
            step(st_writeback);
            repeat ($urandom_range(0, 2)) step(st_idle);
        end

        assert_fails = u_mips_ctrl_top.u_mips_ctrl_assert.assert_failures;
        $display("done: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
hw/mips_ctrl_pkg.sv
hw/instr_classifier.sv
hw/datapath_ctrl.sv
hw/alu_ctrl.sv
hw/mem_ctrl.sv
hw/mips_ctrl_top.sv
verification/tb_clk_gen.sv
verification/mips_ctrl_assert.sv
verification/tb_mips_ctrl.sv

/* Bender.yml */
package:
  name: mips_ctrl

sources:
  - hw/mips_ctrl_pkg.sv
  - hw/instr_classifier.sv
  - hw/datapath_ctrl.sv
  - hw/alu_ctrl.sv
  - hw/mem_ctrl.sv
  - hw/mips_ctrl_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/mips_ctrl_assert.sv
      - verification/tb_mips_ctrl.sv
